// File: logic/lsu_pkg.sv
package lsu_pkg;

    // ------------------------------------------------------------------
    // Widths and memory geometry.
    // ------------------------------------------------------------------

    // Data path width.
    localparam int WORD_W    = 32;
    // Unified memory size in bytes.
    localparam int MEM_BYTES = 16384;
    // Number of 32-bit words.
    localparam int MEM_WORDS = MEM_BYTES / 4;
    // Word index width, log2 of MEM_WORDS.
    localparam int IDX_W     = 12;

    // Vector types with a meaning of their own.
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [31:0]       addr_t;
    typedef logic [IDX_W-1:0]  word_idx_t;
    typedef logic [3:0]        lanes_t;
    typedef logic [2:0]        funct3_t;
    typedef logic [1:0]        boff_t;

    // ------------------------------------------------------------------
    // RV32 load/store funct3 codes.
    // ------------------------------------------------------------------
    localparam funct3_t F3_B  = 3'd0;
    localparam funct3_t F3_H  = 3'd1;
    localparam funct3_t F3_W  = 3'd2;
    localparam funct3_t F3_BU = 3'd4;
    localparam funct3_t F3_HU = 3'd5;

    // Load bookkeeping, travels beside the read data.
    typedef struct packed {
        logic    valid;
        boff_t   boff;
        funct3_t funct3;
    } load_ctl_t;

    // Decoded request from stage 1 into the memory.
    typedef struct packed {
        logic      we;
        word_idx_t idx;
        lanes_t    lanes;
        word_t     wdata;
        load_ctl_t ld;
    } mem_req_t;

endpackage

// File: logic/store_align.sv
`timescale 1ns/1ps

module store_align (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req,
    input  logic              we,
    input  lsu_pkg::funct3_t  funct3,
    input  lsu_pkg::addr_t    addr,
    input  lsu_pkg::word_t    wdata,
    output lsu_pkg::mem_req_t s1_req
);

    // ------------------------------------------------------------------
    // Request decode.
    // ------------------------------------------------------------------

    // Offset actually used by this width, low bits dropped if misaligned.
    lsu_pkg::boff_t     eff_boff;
    // Lanes of the access before shifting.
    lsu_pkg::lanes_t    base_lanes;
    lsu_pkg::lanes_t    lanes_d;
    lsu_pkg::word_t     wdata_sh;
    lsu_pkg::word_idx_t idx_d;

    // Registered request fields.
    logic               we_q;
    logic               ld_valid_q;
    lsu_pkg::word_idx_t idx_q;
    lsu_pkg::lanes_t    lanes_q;
    lsu_pkg::word_t     wdata_q;
    lsu_pkg::boff_t     boff_q;
    lsu_pkg::funct3_t   funct3_q;

    // Width decides lane count and which offset bits count.
    always_comb begin
        case (funct3)
            lsu_pkg::F3_B, lsu_pkg::F3_BU: begin
                eff_boff   = addr[1:0];
                base_lanes = 4'b0001;
            end
            lsu_pkg::F3_H, lsu_pkg::F3_HU: begin
                eff_boff   = {addr[1], 1'b0};
                base_lanes = 4'b0011;
            end
            default: begin
                // Full word, offset ignored.
                eff_boff   = 2'b00;
                base_lanes = 4'b1111;
            end
        endcase
    end

    // Little endian, so byte offset n is lane n.
    assign lanes_d  = base_lanes << eff_boff;
    // Move store data up into its lanes.
    assign wdata_sh = wdata << {eff_boff, 3'b000};
    // Address wraps at MEM_BYTES, then drop the byte bits.
    assign idx_d    = addr[lsu_pkg::IDX_W+1:2];

    // ------------------------------------------------------------------
    // Stage 1 registers.
    // ------------------------------------------------------------------

    // Control.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            we_q       <= 1'b0;
            ld_valid_q <= 1'b0;
        end else begin
            we_q       <= req & we;
            ld_valid_q <= req & ~we;
        end
    end

    // Payload, qualified by the control bits above.
    always_ff @(posedge clk) begin
        idx_q    <= idx_d;
        lanes_q  <= lanes_d;
        wdata_q  <= wdata_sh;
        boff_q   <= eff_boff;
        funct3_q <= funct3;
    end

    assign s1_req.we        = we_q;
    assign s1_req.idx       = idx_q;
    assign s1_req.lanes     = lanes_q;
    assign s1_req.wdata     = wdata_q;
    assign s1_req.ld.valid  = ld_valid_q;
    assign s1_req.ld.boff   = boff_q;
    assign s1_req.ld.funct3 = funct3_q;

endmodule

// File: logic/unified_mem.sv
`timescale 1ns/1ps

module unified_mem (
    input  logic               clk,
    input  logic               rst_n,
    input  lsu_pkg::mem_req_t  s1_req,
    input  lsu_pkg::addr_t     fetch_addr,
    output lsu_pkg::word_t     inst,
    output lsu_pkg::word_t     rdata,
    output lsu_pkg::load_ctl_t s2_ld
);

    // ------------------------------------------------------------------
    // Storage.
    // ------------------------------------------------------------------

    // One word per entry, lane 0 in bits 7:0.
    lsu_pkg::word_t     mem [lsu_pkg::MEM_WORDS];

    // Fetch index, wraps at MEM_BYTES like the data side.
    lsu_pkg::word_idx_t fetch_idx;

    // Read-side registers.
    lsu_pkg::word_t     rdata_q;
    lsu_pkg::word_t     inst_q;

    // Load control delay stage.
    logic               ld_valid_q;
    lsu_pkg::boff_t     ld_boff_q;
    lsu_pkg::funct3_t   ld_funct3_q;

    assign fetch_idx = fetch_addr[lsu_pkg::IDX_W+1:2];

    // ------------------------------------------------------------------
    // Data port write and both reads.
    // ------------------------------------------------------------------

    // Reads see the old word on a same-edge write.
    always_ff @(posedge clk) begin
        rdata_q <= mem[s1_req.idx];
        inst_q  <= mem[fetch_idx];
        if (s1_req.we) begin
            // Only enabled lanes change.
            for (int i = 0; i < 4; i++) begin
                if (s1_req.lanes[i]) begin
                    mem[s1_req.idx][8*i +: 8] <= s1_req.wdata[8*i +: 8];
                end
            end
        end
    end

    assign rdata = rdata_q;
    assign inst  = inst_q;

    // ------------------------------------------------------------------
    // Load control, one stage to line up with rdata.
    // ------------------------------------------------------------------

    // Valid bit.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ld_valid_q <= 1'b0;
        end else begin
            ld_valid_q <= s1_req.ld.valid;
        end
    end

    // Offset and width follow along.
    always_ff @(posedge clk) begin
        ld_boff_q   <= s1_req.ld.boff;
        ld_funct3_q <= s1_req.ld.funct3;
    end

    assign s2_ld.valid  = ld_valid_q;
    assign s2_ld.boff   = ld_boff_q;
    assign s2_ld.funct3 = ld_funct3_q;

endmodule

// File: logic/load_extract.sv
`timescale 1ns/1ps

module load_extract (
    input  logic               clk,
    input  logic               rst_n,
    input  lsu_pkg::word_t     rdata,
    input  lsu_pkg::load_ctl_t s2_ld,
    output logic               load_valid,
    output lsu_pkg::word_t     load_data
);

    // ------------------------------------------------------------------
    // Lane select and extension.
    // ------------------------------------------------------------------

    // Addressed byte moved down to lane 0.
    lsu_pkg::word_t shifted;
    // Result before the output register.
    lsu_pkg::word_t ext_data;

    // Output registers.
    logic           valid_q;
    lsu_pkg::word_t data_q;

    // Offset is already width-aligned from stage 1.
    assign shifted = rdata >> {s2_ld.boff, 3'b000};

    always_comb begin
        case (s2_ld.funct3)
            // Signed byte.
            lsu_pkg::F3_B: begin
                ext_data = {{24{shifted[7]}}, shifted[7:0]};
            end
            // Signed half.
            lsu_pkg::F3_H: begin
                ext_data = {{16{shifted[15]}}, shifted[15:0]};
            end
            // Unsigned byte.
            lsu_pkg::F3_BU: begin
                ext_data = {24'd0, shifted[7:0]};
            end
            // Unsigned half.
            lsu_pkg::F3_HU: begin
                ext_data = {16'd0, shifted[15:0]};
            end
            default: begin
                ext_data = shifted;
            end
        endcase
    end

    // ------------------------------------------------------------------
    // Stage 3 registers.
    // ------------------------------------------------------------------

    // One pulse per load.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= s2_ld.valid;
        end
    end

    // Data only means something with load_valid.
    always_ff @(posedge clk) begin
        data_q <= ext_data;
    end

    assign load_valid = valid_q;
    assign load_data  = data_q;

endmodule

// File: logic/mem_subsys.sv
`timescale 1ns/1ps

module mem_subsys (
    input  logic             clk,
    input  logic             rst_n,
    // Instruction fetch.
    input  lsu_pkg::addr_t   fetch_addr,
    output lsu_pkg::word_t   inst,
    // Data request.
    input  logic             req,
    input  logic             we,
    input  lsu_pkg::funct3_t funct3,
    input  lsu_pkg::addr_t   addr,
    input  lsu_pkg::word_t   wdata,
    // Load result.
    output logic             load_valid,
    output lsu_pkg::word_t   load_data
);

    // ------------------------------------------------------------------
    // Pipeline wiring.
    // ------------------------------------------------------------------

    // Stage 1 to stage 2.
    lsu_pkg::mem_req_t  s1_req;
    // Stage 2 to stage 3.
    lsu_pkg::word_t     rdata;
    lsu_pkg::load_ctl_t s2_ld;

    // Decode and align.
    store_align u_store_align (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (req),
        .we     (we),
        .funct3 (funct3),
        .addr   (addr),
        .wdata  (wdata),
        .s1_req (s1_req)
    );

    // Memory, shared with fetch.
    unified_mem u_unified_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .s1_req     (s1_req),
        .fetch_addr (fetch_addr),
        .inst       (inst),
        .rdata      (rdata),
        .s2_ld      (s2_ld)
    );

    // Extract and extend.
    load_extract u_load_extract (
        .clk        (clk),
        .rst_n      (rst_n),
        .rdata      (rdata),
        .s2_ld      (s2_ld),
        .load_valid (load_valid),
        .load_data  (load_data)
    );

endmodule

// File: dv/mem_subsys_chk.sv
`timescale 1ns/1ps

module mem_subsys_chk (
    input logic           clk,
    input logic           rst_n,
    input logic           s1_ld_valid,
    input logic           load_valid,
    input lsu_pkg::word_t load_data
);

    // A stage 1 load shows up at the output two edges later.
    a_load_latency: assert property (@(posedge clk) disable iff (!rst_n)
        s1_ld_valid |-> ##2 load_valid)
        else $error("load_valid missing two edges after a stage 1 load");

    // Result is fully known while it is valid.
    a_data_known: assert property (@(posedge clk) disable iff (!rst_n)
        load_valid |-> !$isunknown(load_data))
        else $error("load_data has X or Z bits while load_valid is high");

    // No result while held in reset.
    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !load_valid)
        else $error("load_valid high during reset");

endmodule

// Stage 1 and stage 3 both live in the top, so attach there.
bind mem_subsys mem_subsys_chk u_mem_subsys_chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .s1_ld_valid (s1_req.ld.valid),
    .load_valid  (load_valid),
    .load_data   (load_data)
);

// File: dv/mem_subsys_tb.sv
`timescale 1ns/1ps

module mem_subsys_tb;

    // Random phase length and a bound on the directed cycles.
    localparam int N_RAND = 400;
    localparam int N_OPS  = N_RAND + 120;

    logic             clk = 1'b0;
    logic             rst_n;
    lsu_pkg::addr_t   fetch_addr;
    lsu_pkg::word_t   inst;
    logic             req;
    logic             we;
    lsu_pkg::funct3_t funct3;
    lsu_pkg::addr_t   addr;
    lsu_pkg::word_t   wdata;
    logic             load_valid;
    lsu_pkg::word_t   load_data;

    // Byte model of the memory with a written flag per byte.
    logic [7:0] mem_b  [lsu_pkg::MEM_BYTES];
    bit         mem_ok [lsu_pkg::MEM_BYTES];

    // Outstanding loads in issue order.
    lsu_pkg::word_t   exp_q[$];
    int               issue_q[$];
    string            name_q[$];
    // Word-aligned addresses written by full-word stores.
    lsu_pkg::addr_t   word_q[$];

    int               cycle       = 0;
    int               n_loads     = 0;
    int               n_valid     = 0;
    int               last_st_idx = -1;
    lsu_pkg::word_t   rng         = 32'd55;

    mem_subsys u_mem_subsys (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_addr (fetch_addr),
        .inst       (inst),
        .req        (req),
        .we         (we),
        .funct3     (funct3),
        .addr       (addr),
        .wdata      (wdata),
        .load_valid (load_valid),
        .load_data  (load_data)
    );

    // 100 ns period.
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // ------------------------------------------------------------------
    // Helpers.
    // ------------------------------------------------------------------

    function automatic lsu_pkg::word_t xorshift32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic void fail_now(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endfunction

    task automatic check_value(input string name, input lsu_pkg::word_t exp,
                               input lsu_pkg::word_t act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    endtask

    function automatic int byte_count(input lsu_pkg::funct3_t f3);
        if (f3 == lsu_pkg::F3_B || f3 == lsu_pkg::F3_BU) begin
            return 1;
        end
        if (f3 == lsu_pkg::F3_H || f3 == lsu_pkg::F3_HU) begin
            return 2;
        end
        return 4;
    endfunction

    // First model byte of an access after wrap and width alignment.
    function automatic int base_byte(input lsu_pkg::addr_t a, input int nb);
        int b;
        b = int'(a % lsu_pkg::MEM_BYTES);
        return b - (b % nb);
    endfunction

    function automatic void model_store(input lsu_pkg::addr_t a, input lsu_pkg::funct3_t f3,
                                        input lsu_pkg::word_t d);
        int nb;
        int base;
        nb   = byte_count(f3);
        base = base_byte(a, nb);
        // Low bytes of the store data land at ascending addresses.
        for (int i = 0; i < nb; i++) begin
            mem_b[base + i]  = d[8*i +: 8];
            mem_ok[base + i] = 1'b1;
        end
    endfunction

    // Reference gathers bytes little endian and extends by funct3.
    function automatic lsu_pkg::word_t expected_load(input lsu_pkg::addr_t a,
                                                     input lsu_pkg::funct3_t f3);
        int             nb;
        int             base;
        lsu_pkg::word_t v;
        nb   = byte_count(f3);
        base = base_byte(a, nb);
        v    = '0;
        for (int i = 0; i < nb; i++) begin
            if (!mem_ok[base + i]) begin
                fail_now("Stimulus loads a byte that was never written");
            end
            v[8*i +: 8] = mem_b[base + i];
        end
        if (f3 == lsu_pkg::F3_B && v[7]) begin
            v[31:8] = '1;
        end
        if (f3 == lsu_pkg::F3_H && v[15]) begin
            v[31:16] = '1;
        end
        return v;
    endfunction

    // One request per falling edge.
    task automatic drive_req(input logic r, input logic w, input lsu_pkg::funct3_t f3,
                             input lsu_pkg::addr_t a, input lsu_pkg::word_t d);
        @(negedge clk);
        req    = r;
        we     = w;
        funct3 = f3;
        addr   = a;
        wdata  = d;
    endtask

    task automatic do_idle(input int n);
        repeat (n) drive_req(1'b0, 1'b0, lsu_pkg::F3_W, '0, '0);
    endtask

    task automatic do_store(input lsu_pkg::addr_t a, input lsu_pkg::funct3_t f3,
                            input lsu_pkg::word_t d);
        drive_req(1'b1, 1'b1, f3, a, d);
        model_store(a, f3, d);
        last_st_idx = int'(a % lsu_pkg::MEM_BYTES) / 4;
        if (f3 == lsu_pkg::F3_W) begin
            word_q.push_back(a);
        end
    endtask

    task automatic do_load(input string name, input lsu_pkg::addr_t a,
                           input lsu_pkg::funct3_t f3);
        drive_req(1'b1, 1'b0, f3, a, '0);
        exp_q.push_back(expected_load(a, f3));
        issue_q.push_back(cycle);
        name_q.push_back(name);
        n_loads++;
        last_st_idx = -1;
    endtask

    // Fetch result is checked one cycle after the address.
    task automatic check_fetch(input lsu_pkg::addr_t a);
        drive_req(1'b0, 1'b0, lsu_pkg::F3_W, '0, '0);
        fetch_addr = a;
        @(negedge clk);
        check_value("fetch", expected_load(a, lsu_pkg::F3_W), inst);
    endtask

    // ------------------------------------------------------------------
    // Compare process samples between edges.
    // ------------------------------------------------------------------
    always @(negedge clk) begin
        if (!rst_n && load_valid) begin
            fail_now("load_valid went high during reset");
        end else if (load_valid) begin
            n_valid++;
            if (exp_q.size() == 0) begin
                fail_now("load_valid pulsed with no load outstanding");
            end else begin
                check_value({name_q[0], " latency"}, 32'd3, 32'(cycle - issue_q[0]));
                check_value(name_q[0], exp_q[0], load_data);
                void'(exp_q.pop_front());
                void'(issue_q.pop_front());
                void'(name_q.pop_front());
            end
        end
    end

    // Watchdog allows two clock periods per operation plus slack.
    initial begin
        #((N_OPS + 20) * 100 * 2);
        $display("Timeout: the run did not finish in time");
        $display("*** TEST FAILED ***");
        $fatal(1);
    end

    // ------------------------------------------------------------------
    // Stimulus.
    // ------------------------------------------------------------------
    initial begin
        lsu_pkg::funct3_t ld_codes [5];
        lsu_pkg::funct3_t st_codes [3];
        lsu_pkg::addr_t   a;
        lsu_pkg::word_t   r;
        lsu_pkg::word_t   hi;
        lsu_pkg::funct3_t f3;
        ld_codes   = '{lsu_pkg::F3_B, lsu_pkg::F3_H, lsu_pkg::F3_W, lsu_pkg::F3_BU,
                       lsu_pkg::F3_HU};
        st_codes   = '{lsu_pkg::F3_B, lsu_pkg::F3_H, lsu_pkg::F3_W};
        rst_n      = 1'b0;
        req        = 1'b0;
        we         = 1'b0;
        funct3     = lsu_pkg::F3_W;
        addr       = '0;
        wdata      = '0;
        fetch_addr = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Word stores and their read back.
        for (int i = 0; i < 8; i++) begin
            do_store(32'h100 + 4*i, lsu_pkg::F3_W, xorshift32());
        end
        do_idle(2);
        for (int i = 0; i < 8; i++) begin
            do_load("word", 32'h100 + 4*i, lsu_pkg::F3_W);
        end

        // Byte and half merging where upper wdata bits must not leak.
        for (int i = 0; i < 4; i++) begin
            do_store(32'h200, lsu_pkg::F3_W, 32'h11223344);
            do_store(32'h200 + i, lsu_pkg::F3_B, 32'hDEADBEA0 + i);
            do_idle(1);
            do_load("sb merge", 32'h200, lsu_pkg::F3_W);
        end
        for (int i = 0; i < 2; i++) begin
            do_store(32'h200, lsu_pkg::F3_W, 32'h11223344);
            do_store(32'h200 + 2*i, lsu_pkg::F3_H, 32'hCAFEBEE0 + i);
            do_idle(1);
            do_load("sh merge", 32'h200, lsu_pkg::F3_W);
        end

        // Extension with top bits set and clear.
        do_store(32'h300, lsu_pkg::F3_W, 32'h80F17F01);
        do_store(32'h304, lsu_pkg::F3_W, 32'h7FFF8000);
        do_idle(1);
        for (int w = 0; w < 2; w++) begin
            for (int i = 0; i < 4; i++) begin
                do_load("lb", 32'h300 + 4*w + i, lsu_pkg::F3_B);
                do_load("lbu", 32'h300 + 4*w + i, lsu_pkg::F3_BU);
            end
            for (int i = 0; i < 2; i++) begin
                do_load("lh", 32'h300 + 4*w + 2*i, lsu_pkg::F3_H);
                do_load("lhu", 32'h300 + 4*w + 2*i, lsu_pkg::F3_HU);
            end
        end

        // Fetch port over plain and aliased addresses.
        for (int i = 0; i < 8; i++) begin
            check_fetch(32'h100 + 4*i + (i << 14) + (i[0] ? 32'hFFFF_0000 : 0));
        end

        // Store-only burst yields no results.
        for (int i = 0; i < 16; i++) begin
            do_store(xorshift32() & ~32'h3, lsu_pkg::F3_W, xorshift32());
        end

        // Back-to-back random traffic over full 32-bit addresses.
        for (int n = 0; n < N_RAND; n++) begin
            r  = xorshift32();
            a  = word_q[r[31:8] % word_q.size()];
            hi = xorshift32();
            a  = {hi[31:14], a[13:2], r[6:5]};
            f3 = ld_codes[r[4:2] % 5];
            if (r[0] && int'(a % lsu_pkg::MEM_BYTES) / 4 != last_st_idx) begin
                if (byte_count(f3) == 2) begin
                    a[0] = 1'b0;
                end else if (byte_count(f3) == 4) begin
                    a[1:0] = 2'b00;
                end
                do_load("random", a, f3);
            end else begin
                a  = xorshift32();
                f3 = st_codes[r[3:1] % 3];
                a  = a & ~(byte_count(f3) - 1);
                do_store(a, f3, xorshift32());
            end
        end

        // Drain the pipeline.
        do_idle(6);
        if (exp_q.size() != 0 || n_valid != n_loads) begin
            $display("Result count wrong: %0d loads issued, %0d results seen",
                     n_loads, n_valid);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

// File: src.f
logic/lsu_pkg.sv
logic/store_align.sv
logic/unified_mem.sv
logic/load_extract.sv
logic/mem_subsys.sv
dv/mem_subsys_chk.sv
dv/mem_subsys_tb.sv
